//--- Makefile
# Verilator flow for the riscv_csr project

VERILATOR   ?= verilator
FILELIST    ?= riscv_csr.f
TB_TOP      ?= tb_csr_file
RTL_TOP     ?= csr_file
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
LINT_FLAGS  ?= --timing -Wall
BUILD_FLAGS ?= --timing -Wno-fatal
PASS_TEXT   ?= sim passed

SOURCES := $(wildcard src/*.sv include/*.svh testbench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TB_TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(BUILD_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation failure, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// datapath widths
`define CSR_XLEN    32
`define CSR_CNT_W   64
`define CSR_ADDR_W  12
`define CSR_IMM_W   5

// misa for rv32, extensions i and m
`define CSR_MISA_VAL 32'h4000_1100

// previous privilege after reset is machine
`define CSR_MSTATUS_MPP_RST 2'b11

// identification registers, hardwired
`define CSR_MVENDORID_VAL 32'h0000_0000
`define CSR_MARCHID_VAL   32'h0000_0000
`define CSR_MIMPID_VAL    32'h0000_0000
`define CSR_MHARTID_VAL   32'h0000_0000

`endif

//--- riscv_csr.f
+incdir+include
src/csr_isa_pkg.sv
src/csr_types_pkg.sv
src/csr_write_data.sv
src/csr_trap_ctrl.sv
src/csr_machine_regs.sv
src/csr_counters.sv
src/csr_file.sv
testbench/tb_csr_file.sv

//--- src/csr_counters.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_defines.svh"

module csr_counters (
    input  wire logic                   CLK,
    input  wire logic                   RST,
    input  wire logic                   proc_idle,
    input  wire csr_types_pkg::csr_wr_t wr,
    output csr_types_pkg::counter_t     mcycle,
    output csr_types_pkg::counter_t     minstret
);
    import csr_types_pkg::*;
    import csr_isa_pkg::*;

    logic wr_cyc_lo;
    logic wr_cyc_hi;
    logic wr_ret_lo;
    logic wr_ret_hi;

    // a write to either half replaces the increment
    function automatic counter_t next_count(
        input counter_t cur,
        input logic     wr_lo,
        input logic     wr_hi,
        input xlen_t    data
    );
        counter_t nxt;
        nxt = cur + 1'b1;
        if (wr_lo)
            nxt = {cur[`CSR_CNT_W-1:`CSR_XLEN], data};
        else if (wr_hi)
            nxt = {data, cur[`CSR_XLEN-1:0]};
        return nxt;
    endfunction

    assign wr_cyc_lo = wr.en & (wr.addr == addr_mcycle);
    assign wr_cyc_hi = wr.en & (wr.addr == addr_mcycleh);
    assign wr_ret_lo = wr.en & (wr.addr == addr_minstret);
    assign wr_ret_hi = wr.en & (wr.addr == addr_minstreth);

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            mcycle   <= '0;
            minstret <= '0;
        end
        else
        begin
            // mcycle keeps running through stalls
            mcycle <= next_count(mcycle, wr_cyc_lo, wr_cyc_hi, wr.data);
            if (!proc_idle)
                minstret <= next_count(minstret, wr_ret_lo, wr_ret_hi, wr.data);
        end
    end

endmodule

`default_nettype wire

//--- src/csr_file.sv
`timescale 1ns/1ns
`default_nettype none

module csr_file (
    input  wire logic                      CLK,
    input  wire logic                      RST,
    input  wire csr_types_pkg::csr_req_t   req,
    input  wire csr_types_pkg::xlen_t      pc,
    input  wire csr_types_pkg::irq_lines_t irq,
    input  wire logic                      proc_idle,
    output csr_types_pkg::xlen_t           rdata,
    output csr_types_pkg::xlen_t           jump_addr,
    output logic                           priv_jump,
    output logic                           trap_final
);
    import csr_types_pkg::*;
    import csr_isa_pkg::*;

    trap_update_t upd;
    csr_wr_t      wr;
    counter_t     mcycle;
    counter_t     minstret;
    xlen_t        mtvec;
    xlen_t        mepc;
    logic         mstatus_mie;
    logic         meie;
    logic         mtie;
    priv_e        mpp;

    //////////////////////////////////////////////////////////////////////
    // operand merge and trap control
    //////////////////////////////////////////////////////////////////////
    csr_write_data i_write_data (
        .req       (req),
        .cur_value (rdata),
        .trap      (trap_final),
        .proc_idle (proc_idle),
        .wr        (wr)
    );

    csr_trap_ctrl i_trap_ctrl (
        .CLK         (CLK),
        .RST         (RST),
        .req         (req),
        .pc          (pc),
        .irq         (irq),
        .proc_idle   (proc_idle),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .mstatus_mie (mstatus_mie),
        .meie        (meie),
        .mtie        (mtie),
        .mpp         (mpp),
        .upd         (upd),
        .priv_jump   (priv_jump),
        .trap_final  (trap_final),
        .jump_addr   (jump_addr)
    );

    //////////////////////////////////////////////////////////////////////
    // register state
    //////////////////////////////////////////////////////////////////////
    csr_machine_regs i_machine_regs (
        .CLK         (CLK),
        .RST         (RST),
        .proc_idle   (proc_idle),
        .wr          (wr),
        .upd         (upd),
        .irq         (irq),
        .addr        (req.addr),
        .mcycle      (mcycle),
        .minstret    (minstret),
        .rdata       (rdata),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .mstatus_mie (mstatus_mie),
        .meie        (meie),
        .mtie        (mtie),
        .mpp         (mpp)
    );

    csr_counters i_counters (
        .CLK       (CLK),
        .RST       (RST),
        .proc_idle (proc_idle),
        .wr        (wr),
        .mcycle    (mcycle),
        .minstret  (minstret)
    );

endmodule

`default_nettype wire

//--- src/csr_isa_pkg.sv
`default_nettype none

`include "csr_defines.svh"

package csr_isa_pkg;

    //////////////////////////////////////////////////////////////////////
    // operation codes from the decoder
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        op_none   = 4'd0,
        op_csrrw  = 4'd1,
        op_csrrs  = 4'd2,
        op_csrrc  = 4'd3,
        op_csrrwi = 4'd4,
        op_csrrsi = 4'd5,
        op_csrrci = 4'd6,
        op_ecall  = 4'd7,
        op_ebreak = 4'd8,
        op_mret   = 4'd9
    } csr_op_e;

    //////////////////////////////////////////////////////////////////////
    // supported csr addresses
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [`CSR_ADDR_W-1:0] {
        addr_mstatus   = 12'h300,
        addr_misa      = 12'h301,
        addr_mie       = 12'h304,
        addr_mtvec     = 12'h305,
        addr_mscratch  = 12'h340,
        addr_mepc      = 12'h341,
        addr_mcause    = 12'h342,
        addr_mtval     = 12'h343,
        addr_mip       = 12'h344,
        addr_mcycle    = 12'hB00,
        addr_minstret  = 12'hB02,
        addr_mcycleh   = 12'hB80,
        addr_minstreth = 12'hB82,
        // user read-only aliases
        addr_cycle     = 12'hC00,
        addr_instret   = 12'hC02,
        addr_cycleh    = 12'hC80,
        addr_instreth  = 12'hC82,
        addr_mvendorid = 12'hF11,
        addr_marchid   = 12'hF12,
        addr_mimpid    = 12'hF13,
        addr_mhartid   = 12'hF14
    } csr_addr_e;

    typedef enum logic [1:0] {
        priv_user    = 2'd0,
        priv_machine = 2'd3
    } priv_e;

    // mcause values, msb marks an interrupt
    localparam logic [`CSR_XLEN-1:0] CAUSE_M_EXT_IRQ   = {1'b1, 31'd11};
    localparam logic [`CSR_XLEN-1:0] CAUSE_M_TIMER_IRQ = {1'b1, 31'd7};
    localparam logic [`CSR_XLEN-1:0] CAUSE_ECALL_U     = 32'd8;
    localparam logic [`CSR_XLEN-1:0] CAUSE_ECALL_M     = 32'd11;
    localparam logic [`CSR_XLEN-1:0] CAUSE_BREAK       = 32'd3;
    localparam logic [`CSR_XLEN-1:0] CAUSE_ILLEGAL     = 32'd2;

endpackage

`default_nettype wire

//--- src/csr_machine_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_defines.svh"

module csr_machine_regs (
    input  wire logic                        CLK,
    input  wire logic                        RST,
    input  wire logic                        proc_idle,
    input  wire csr_types_pkg::csr_wr_t      wr,
    input  wire csr_types_pkg::trap_update_t upd,
    input  wire csr_types_pkg::irq_lines_t   irq,
    input  wire csr_types_pkg::csr_addr_t    addr,
    input  wire csr_types_pkg::counter_t     mcycle,
    input  wire csr_types_pkg::counter_t     minstret,
    output csr_types_pkg::xlen_t             rdata,
    output csr_types_pkg::xlen_t             mtvec,
    output csr_types_pkg::xlen_t             mepc,
    output logic                             mstatus_mie,
    output logic                             meie,
    output logic                             mtie,
    output csr_isa_pkg::priv_e               mpp
);
    import csr_types_pkg::*;
    import csr_isa_pkg::*;

    logic  mstatus_mpie;
    xlen_t mscratch;
    xlen_t mcause;
    xlen_t mtval;
    xlen_t mstatus_r;
    xlen_t mie_r;
    xlen_t mip_r;

    //////////////////////////////////////////////////////////////////////
    // register bank
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mpp          <= priv_e'(`CSR_MSTATUS_MPP_RST);
            meie         <= 1'b0;
            mtie         <= 1'b0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
        end
        else if (!proc_idle)
        begin
            // trap entry and mret first, csr write after
            if (upd.take_trap)
            begin
                mepc         <= upd.epc;
                mcause       <= upd.cause;
                mpp          <= upd.prev_priv;
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
            end
            else if (upd.do_mret)
            begin
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
                mpp          <= priv_user;
            end

            if (wr.en)
            begin
                case (csr_addr_e'(wr.addr))
                    addr_mstatus:
                    begin
                        mstatus_mie  <= wr.data[3];
                        mstatus_mpie <= wr.data[7];
                        // only user and machine are legal in mpp
                        mpp <= (wr.data[12:11] == 2'b11) ? priv_machine : priv_user;
                    end
                    addr_mie:
                    begin
                        meie <= wr.data[11];
                        mtie <= wr.data[7];
                    end
                    addr_mtvec:    mtvec    <= wr.data;
                    addr_mscratch: mscratch <= wr.data;
                    addr_mepc:     mepc     <= wr.data;
                    addr_mcause:   mcause   <= wr.data;
                    addr_mtval:    mtval    <= wr.data;
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read mux
    //////////////////////////////////////////////////////////////////////
    assign mstatus_r = xlen_t'({mpp, 3'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0});
    assign mie_r     = xlen_t'({meie, 3'b0, mtie, 7'b0});
    // software interrupt is visible here only
    assign mip_r     = xlen_t'({irq.meip, 3'b0, irq.mtip, 3'b0, irq.msip, 3'b0});

    always_comb
    begin
        case (csr_addr_e'(addr))
            addr_mstatus:                  rdata = mstatus_r;
            addr_misa:                     rdata = `CSR_MISA_VAL;
            addr_mie:                      rdata = mie_r;
            addr_mtvec:                    rdata = mtvec;
            addr_mscratch:                 rdata = mscratch;
            addr_mepc:                     rdata = mepc;
            addr_mcause:                   rdata = mcause;
            addr_mtval:                    rdata = mtval;
            addr_mip:                      rdata = mip_r;
            addr_mcycle, addr_cycle:       rdata = mcycle[`CSR_XLEN-1:0];
            addr_mcycleh, addr_cycleh:     rdata = mcycle[`CSR_CNT_W-1:`CSR_XLEN];
            addr_minstret, addr_instret:   rdata = minstret[`CSR_XLEN-1:0];
            addr_minstreth, addr_instreth: rdata = minstret[`CSR_CNT_W-1:`CSR_XLEN];
            addr_mvendorid:                rdata = `CSR_MVENDORID_VAL;
            addr_marchid:                  rdata = `CSR_MARCHID_VAL;
            addr_mimpid:                   rdata = `CSR_MIMPID_VAL;
            addr_mhartid:                  rdata = `CSR_MHARTID_VAL;
            default:                       rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/csr_trap_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module csr_trap_ctrl (
    input  wire logic                      CLK,
    input  wire logic                      RST,
    input  wire csr_types_pkg::csr_req_t   req,
    input  wire csr_types_pkg::xlen_t      pc,
    input  wire csr_types_pkg::irq_lines_t irq,
    input  wire logic                      proc_idle,
    input  wire csr_types_pkg::xlen_t      mtvec,
    input  wire csr_types_pkg::xlen_t      mepc,
    input  wire logic                      mstatus_mie,
    input  wire logic                      meie,
    input  wire logic                      mtie,
    input  wire csr_isa_pkg::priv_e        mpp,
    output csr_types_pkg::trap_update_t    upd,
    output logic                           priv_jump,
    output logic                           trap_final,
    output csr_types_pkg::xlen_t           jump_addr
);
    import csr_types_pkg::*;
    import csr_isa_pkg::*;

    priv_e cur_priv;
    logic  ext_irq;
    logic  tmr_irq;
    logic  interrupt;
    logic  csr_op;
    logic  illegal;
    logic  is_ecall;
    logic  is_ebreak;
    logic  is_mret;
    logic  exception;
    xlen_t cause;

    //////////////////////////////////////////////////////////////////////
    // trap detection
    //////////////////////////////////////////////////////////////////////
    assign ext_irq   = mstatus_mie & meie & irq.meip;
    assign tmr_irq   = mstatus_mie & mtie & irq.mtip;
    assign interrupt = ext_irq | tmr_irq;

    assign csr_op    = req.op inside {op_csrrw, op_csrrs, op_csrrc,
                                      op_csrrwi, op_csrrsi, op_csrrci};
    // address bits 9:8 give the lowest privilege allowed
    assign illegal   = csr_op & (req.addr[9:8] > cur_priv);
    assign is_ecall  = (req.op == op_ecall);
    assign is_ebreak = (req.op == op_ebreak);
    assign is_mret   = (req.op == op_mret);
    assign exception = is_ecall | is_ebreak | illegal;

    assign trap_final = interrupt | exception;
    assign priv_jump  = trap_final | is_mret;

    // external, then timer, then synchronous causes
    always_comb
    begin
        if (ext_irq)
            cause = CAUSE_M_EXT_IRQ;
        else if (tmr_irq)
            cause = CAUSE_M_TIMER_IRQ;
        else if (is_ecall)
            cause = (cur_priv == priv_machine) ? CAUSE_ECALL_M : CAUSE_ECALL_U;
        else if (is_ebreak)
            cause = CAUSE_BREAK;
        else
            cause = CAUSE_ILLEGAL;
    end

    // direct mode only, mode bits dropped
    assign jump_addr = trap_final ? (mtvec & ~xlen_t'(3)) : mepc;

    assign upd = '{
        take_trap: trap_final,
        do_mret:   is_mret & ~trap_final,
        cause:     cause,
        epc:       pc,
        prev_priv: cur_priv
    };

    //////////////////////////////////////////////////////////////////////
    // current privilege
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK)
    begin
        if (RST)
            cur_priv <= priv_machine;
        else if (!proc_idle)
        begin
            if (trap_final)
                cur_priv <= priv_machine;
            else if (is_mret)
                cur_priv <= mpp;
        end
    end

endmodule

`default_nettype wire

//--- src/csr_types_pkg.sv
`default_nettype none

`include "csr_defines.svh"

package csr_types_pkg;

    typedef logic [`CSR_XLEN-1:0]   xlen_t;
    typedef logic [`CSR_CNT_W-1:0]  counter_t;
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [`CSR_IMM_W-1:0]  csr_imm_t;

    // one instruction request, imm doubles as the rs1 index
    typedef struct packed {
        csr_isa_pkg::csr_op_e op;
        csr_addr_t            addr;
        xlen_t                rs1_data;
        csr_imm_t             imm;
    } csr_req_t;

    typedef struct packed {
        logic meip;
        logic mtip;
        logic msip;
    } irq_lines_t;

    // trap entry or mret, applied at the next edge
    typedef struct packed {
        logic               take_trap;
        logic               do_mret;
        xlen_t              cause;
        xlen_t              epc;
        csr_isa_pkg::priv_e prev_priv;
    } trap_update_t;

    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        xlen_t     data;
    } csr_wr_t;

endpackage

`default_nettype wire

//--- src/csr_write_data.sv
`timescale 1ns/1ns
`default_nettype none

module csr_write_data (
    input  wire csr_types_pkg::csr_req_t req,
    input  wire csr_types_pkg::xlen_t    cur_value,
    input  wire logic                    trap,
    input  wire logic                    proc_idle,
    output csr_types_pkg::csr_wr_t       wr
);
    import csr_types_pkg::*;
    import csr_isa_pkg::*;

    xlen_t zimm;
    xlen_t new_value;
    logic  csr_op;

    assign zimm = xlen_t'(req.imm);

    // merge operand with the current register value
    always_comb
    begin
        csr_op = 1'b1;
        case (req.op)
            op_csrrw:  new_value = req.rs1_data;
            op_csrrs:  new_value = cur_value | req.rs1_data;
            op_csrrc:  new_value = cur_value & ~req.rs1_data;
            op_csrrwi: new_value = zimm;
            op_csrrsi: new_value = cur_value | zimm;
            op_csrrci: new_value = cur_value & ~zimm;
            default:
            begin
                new_value = '0;
                csr_op    = 1'b0;
            end
        endcase
    end

    // rs1 index zero, a stall or a trap blocks the write
    assign wr = '{
        en:   csr_op & (req.imm != '0) & ~proc_idle & ~trap,
        addr: req.addr,
        data: new_value
    };

endmodule

`default_nettype wire

//--- testbench/tb_csr_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_defines.svh"

module tb_csr_file;
    import csr_isa_pkg::*;
    import csr_types_pkg::*;

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_RAND     = 200;
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 * NUM_RAND + 120;
    localparam int TIMEOUT_NS   = (TEST_CYCLES + 50) * PERIOD;

    typedef struct packed {
        xlen_t rdata;
        logic  priv_jump;
        logic  trap_final;
        xlen_t jump_addr;
    } expect_t;

    logic       CLK = 1'b0;
    logic       RST;
    csr_req_t   req;
    xlen_t      pc;
    irq_lines_t irq;
    logic       proc_idle;
    xlen_t      rdata;
    xlen_t      jump_addr;
    logic       priv_jump;
    logic       trap_final;

    int checks = 0;
    int errors = 0;

    // reference model state
    priv_e    m_priv;
    priv_e    m_mpp;
    logic     m_mie;
    logic     m_mpie;
    logic     m_meie;
    logic     m_mtie;
    xlen_t    m_mtvec;
    xlen_t    m_mscratch;
    xlen_t    m_mepc;
    xlen_t    m_mcause;
    xlen_t    m_mtval;
    counter_t m_mcycle;
    counter_t m_minstret;

    csr_file i_dut (
        .CLK        (CLK),
        .RST        (RST),
        .req        (req),
        .pc         (pc),
        .irq        (irq),
        .proc_idle  (proc_idle),
        .rdata      (rdata),
        .jump_addr  (jump_addr),
        .priv_jump  (priv_jump),
        .trap_final (trap_final)
    );

    always #(PERIOD / 2) CLK = ~CLK;

    task automatic compare_value(input string what, input xlen_t got, input xlen_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////
    task automatic reset_model();
        m_priv     = priv_machine;
        m_mpp      = priv_machine;
        m_mie      = 1'b0;
        m_mpie     = 1'b0;
        m_meie     = 1'b0;
        m_mtie     = 1'b0;
        m_mtvec    = '0;
        m_mscratch = '0;
        m_mepc     = '0;
        m_mcause   = '0;
        m_mtval    = '0;
        m_mcycle   = '0;
        m_minstret = '0;
    endtask

    function automatic xlen_t model_read(input csr_addr_t a, input irq_lines_t ir);
        xlen_t r;
        r = '0;
        case (a)
            addr_mstatus:
            begin
                r[12:11] = m_mpp;
                r[7]     = m_mpie;
                r[3]     = m_mie;
            end
            addr_misa:                     r = `CSR_MISA_VAL;
            addr_mie:
            begin
                r[11] = m_meie;
                r[7]  = m_mtie;
            end
            addr_mip:
            begin
                r[11] = ir.meip;
                r[7]  = ir.mtip;
                r[3]  = ir.msip;
            end
            addr_mtvec:                    r = m_mtvec;
            addr_mscratch:                 r = m_mscratch;
            addr_mepc:                     r = m_mepc;
            addr_mcause:                   r = m_mcause;
            addr_mtval:                    r = m_mtval;
            addr_mcycle, addr_cycle:       r = m_mcycle[31:0];
            addr_mcycleh, addr_cycleh:     r = m_mcycle[63:32];
            addr_minstret, addr_instret:   r = m_minstret[31:0];
            addr_minstreth, addr_instreth: r = m_minstret[63:32];
            // identification registers and unknown addresses
            default:                       r = 32'h0;
        endcase
        return r;
    endfunction

    function automatic logic is_csr_access(input csr_req_t r);
        return (r.op >= op_csrrw) && (r.op <= op_csrrci);
    endfunction

    function automatic logic irq_pending(input irq_lines_t ir);
        return m_mie && ((m_meie && ir.meip) || (m_mtie && ir.mtip));
    endfunction

    function automatic logic exception_present(input csr_req_t r);
        return (r.op == op_ecall) || (r.op == op_ebreak)
            || (is_csr_access(r) && (r.addr[9:8] > m_priv));
    endfunction

    function automatic xlen_t model_cause(input csr_req_t r, input irq_lines_t ir);
        if (m_mie && m_meie && ir.meip)
            return CAUSE_M_EXT_IRQ;
        if (m_mie && m_mtie && ir.mtip)
            return CAUSE_M_TIMER_IRQ;
        if (r.op == op_ecall)
            return (m_priv == priv_machine) ? CAUSE_ECALL_M : CAUSE_ECALL_U;
        if (r.op == op_ebreak)
            return CAUSE_BREAK;
        return CAUSE_ILLEGAL;
    endfunction

    function automatic xlen_t merged_value(input csr_req_t r, input xlen_t cur);
        xlen_t z;
        z = {27'b0, r.imm};
        case (r.op)
            op_csrrw:  return r.rs1_data;
            op_csrrs:  return cur | r.rs1_data;
            op_csrrc:  return cur & ~r.rs1_data;
            op_csrrwi: return z;
            op_csrrsi: return cur | z;
            op_csrrci: return cur & ~z;
            default:   return cur;
        endcase
    endfunction

    function automatic expect_t reference_outputs(input csr_req_t r, input irq_lines_t ir);
        expect_t e;
        e.trap_final = irq_pending(ir) || exception_present(r);
        e.priv_jump  = e.trap_final || (r.op == op_mret);
        e.jump_addr  = e.trap_final ? {m_mtvec[31:2], 2'b00} : m_mepc;
        e.rdata      = model_read(r.addr, ir);
        return e;
    endfunction

    // state after the next rising edge
    task automatic advance_model(input csr_req_t r, input xlen_t pc_v, input irq_lines_t ir,
                                 input logic idle);
        logic  trap;
        logic  wr_en;
        xlen_t wdata;
        xlen_t cause;
        trap  = irq_pending(ir) || exception_present(r);
        cause = model_cause(r, ir);
        wr_en = is_csr_access(r) && (r.imm != 5'd0) && !idle && !trap;
        wdata = merged_value(r, model_read(r.addr, ir));

        if (wr_en && (r.addr == addr_mcycle))
            m_mcycle[31:0] = wdata;
        else if (wr_en && (r.addr == addr_mcycleh))
            m_mcycle[63:32] = wdata;
        else
            m_mcycle = m_mcycle + 64'd1;
        if (idle)
            return;
        if (wr_en && (r.addr == addr_minstret))
            m_minstret[31:0] = wdata;
        else if (wr_en && (r.addr == addr_minstreth))
            m_minstret[63:32] = wdata;
        else
            m_minstret = m_minstret + 64'd1;

        if (trap)
        begin
            m_mepc   = pc_v;
            m_mcause = cause;
            m_mpp    = m_priv;
            m_mpie   = m_mie;
            m_mie    = 1'b0;
            m_priv   = priv_machine;
        end
        else if (r.op == op_mret)
        begin
            m_priv = m_mpp;
            m_mie  = m_mpie;
            m_mpie = 1'b1;
            m_mpp  = priv_user;
        end

        if (wr_en)
        begin
            case (r.addr)
                addr_mstatus:
                begin
                    m_mie  = wdata[3];
                    m_mpie = wdata[7];
                    m_mpp  = (wdata[12:11] == 2'b11) ? priv_machine : priv_user;
                end
                addr_mie:
                begin
                    m_meie = wdata[11];
                    m_mtie = wdata[7];
                end
                addr_mtvec:    m_mtvec    = wdata;
                addr_mscratch: m_mscratch = wdata;
                addr_mepc:     m_mepc     = wdata;
                addr_mcause:   m_mcause   = wdata;
                addr_mtval:    m_mtval    = wdata;
                default: ;
            endcase
        end
    endtask

    // outputs are stable mid-cycle, compare on the falling edge
    always @(negedge CLK)
    begin
        expect_t e;
        if (RST)
            reset_model();
        else
        begin
            e = reference_outputs(req, irq);
            compare_value("rdata", rdata, e.rdata);
            compare_value("priv_jump", xlen_t'(priv_jump), xlen_t'(e.priv_jump));
            compare_value("trap_final", xlen_t'(trap_final), xlen_t'(e.trap_final));
            compare_value("jump_addr", jump_addr, e.jump_addr);
            advance_model(req, pc, irq, proc_idle);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    task automatic drive_req(input csr_op_e op, input csr_addr_t a, input xlen_t rs1,
                             input csr_imm_t imm);
        @(posedge CLK);
        req <= '{op: op, addr: a, rs1_data: rs1, imm: imm};
    endtask

    task automatic read_csr(input csr_addr_t a, output xlen_t v);
        drive_req(op_csrrs, a, '0, '0);
        @(negedge CLK);
        v = rdata;
    endtask

    initial
    begin
        csr_op_e   op;
        csr_addr_t a;
        csr_imm_t  imm;
        xlen_t     v;
        xlen_t     t0;
        xlen_t     t1;
        void'($urandom(32'h709a_82f6));
        RST       = 1'b1;
        req       = '{op: op_none, addr: '0, rs1_data: '0, imm: '0};
        pc        = '0;
        irq       = '0;
        proc_idle = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        RST <= 1'b0;

        // random register and immediate forms on writable registers
        for (int i = 0; i < NUM_RAND; i++)
        begin
            op = csr_op_e'(4'($urandom_range(1, 6)));
            case ($urandom_range(0, 2))
                0:       a = addr_mscratch;
                1:       a = addr_mtvec;
                default: a = addr_mtval;
            endcase
            imm = (i % 8 == 0) ? 5'd0 : 5'($urandom);
            drive_req(op, a, $urandom, imm);
            pc <= $urandom;
            read_csr(a, v);
        end

        // fixed registers
        read_csr(addr_misa, v);
        compare_value("misa", v, `CSR_MISA_VAL);
        read_csr(addr_mvendorid, v);
        compare_value("mvendorid", v, 32'h0);
        read_csr(addr_marchid, v);
        compare_value("marchid", v, 32'h0);
        read_csr(addr_mimpid, v);
        compare_value("mimpid", v, 32'h0);
        read_csr(addr_mhartid, v);
        compare_value("mhartid", v, 32'h0);
        read_csr(12'h7C0, v);
        compare_value("unknown csr", v, 32'h0);

        // counters
        read_csr(addr_mcycle, t0);
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        t1 = rdata;
        compare_value("mcycle delta", t1 - t0, 32'd5);
        read_csr(addr_minstret, v);
        @(posedge CLK);
        proc_idle <= 1'b1;
        @(negedge CLK);
        t0 = rdata;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        t1 = rdata;
        compare_value("minstret stalled", t1, t0);
        @(posedge CLK);
        proc_idle <= 1'b0;
        v = $urandom;
        drive_req(op_csrrw, addr_mcycleh, v, 5'd1);
        read_csr(addr_mcycleh, t1);
        compare_value("mcycleh", t1, v);

        // ecall from machine mode
        drive_req(op_csrrw, addr_mtvec, 32'h0000_2403, 5'd1);
        drive_req(op_ecall, '0, '0, '0);
        pc <= 32'h0000_0a40;
        @(negedge CLK);
        compare_value("ecall priv_jump", xlen_t'(priv_jump), 32'd1);
        compare_value("ecall trap_final", xlen_t'(trap_final), 32'd1);
        compare_value("ecall jump_addr", jump_addr, 32'h0000_2400);
        read_csr(addr_mepc, v);
        compare_value("mepc", v, 32'h0000_0a40);
        read_csr(addr_mcause, v);
        compare_value("mcause ecall", v, 32'd11);

        // external and timer together, external wins
        drive_req(op_csrrs, addr_mie, 32'h0000_0880, 5'd2);
        drive_req(op_csrrsi, addr_mstatus, '0, 5'd8);
        drive_req(op_none, '0, '0, '0);
        irq <= '{meip: 1'b1, mtip: 1'b1, msip: 1'b0};
        pc  <= 32'h0000_1234;
        @(negedge CLK);
        compare_value("irq trap_final", xlen_t'(trap_final), 32'd1);
        @(posedge CLK);
        irq <= '0;
        read_csr(addr_mcause, v);
        compare_value("mcause irq", v, 32'h8000_000b);
        read_csr(addr_mstatus, v);
        compare_value("mstatus.mie after trap", xlen_t'(v[3]), 32'd0);
        drive_req(op_mret, '0, '0, '0);
        @(negedge CLK);
        compare_value("mret priv_jump", xlen_t'(priv_jump), 32'd1);
        compare_value("mret jump_addr", jump_addr, 32'h0000_1234);
        read_csr(addr_mstatus, v);
        compare_value("mstatus.mie after mret", xlen_t'(v[3]), 32'd1);

        // drop to user mode, then an illegal access and a user ecall
        drive_req(op_csrrc, addr_mstatus, 32'h0000_1800, 5'd3);
        drive_req(op_csrrw, addr_mscratch, 32'h5a5a_0001, 5'd4);
        drive_req(op_mret, '0, '0, '0);
        drive_req(op_csrrw, addr_mscratch, 32'hdead_0000, 5'd4);
        @(negedge CLK);
        compare_value("illegal trap_final", xlen_t'(trap_final), 32'd1);
        read_csr(addr_mscratch, v);
        compare_value("mscratch kept", v, 32'h5a5a_0001);
        drive_req(op_mret, '0, '0, '0);
        drive_req(op_ecall, '0, '0, '0);
        @(negedge CLK);
        compare_value("user ecall trap_final", xlen_t'(trap_final), 32'd1);
        read_csr(addr_mcause, v);
        compare_value("mcause user ecall", v, 32'd8);

        drive_req(op_none, '0, '0, '0);
        repeat (2) @(posedge CLK);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    // watchdog
    initial
    begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns before the tests finished", TIMEOUT_NS);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
